// ==== logic/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath and register index widths
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5

// Word address into a 64-word instruction memory
`define IMEM_ADDR_WIDTH 6

// Ring packet header fields
`define NET_ADDR_WIDTH  12
`define RING_ID_WIDTH   4

// The only two opcodes the ALU executes
`define OPCODE_OP       7'b0110011
`define OPCODE_OP_IMM   7'b0010011

// ALU function codes, SUB shares ADD and is told apart by funct7 bit 5
`define FUNCT3_ADD      3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SLT      3'b010
`define FUNCT3_XOR      3'b100
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111
`define FUNCT3_SRL      3'b101

`endif

// ==== logic/core_pkg.sv ====
`include "core_defs.svh"

package core_pkg;

    // Register and instruction words
    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [`DATA_WIDTH-1:0] instr_t;

    // Register index
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Byte address of the fetched instruction
    typedef logic [`DATA_WIDTH-1:0] pc_t;

    // Packet address field, word address for imem and PC writes
    typedef logic [`NET_ADDR_WIDTH-1:0] net_addr_t;

    // Tile identifier on the ring
    typedef logic [`RING_ID_WIDTH-1:0] ring_id_t;

    // Network command carried by a packet
    typedef enum logic [1:0]
    {
        NET_PC    = 2'd0,
        NET_INSTR = 2'd1,
        NET_REG   = 2'd2
    } net_op_e;

    // Core run state
    typedef enum logic
    {
        IDLE = 1'b0,
        RUN  = 1'b1
    } run_state_e;

endpackage

// ==== logic/net_cmd_decode.sv ====
`timescale 1ns/1ns

module net_cmd_decode
#(
    parameter core_pkg::ring_id_t ring_id_p = '0
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                net_valid_i,
    input  logic                net_external_i,
    input  logic                net_bc_i,
    input  core_pkg::ring_id_t  net_ring_id_i,
    input  core_pkg::net_op_e   net_op_i,
    input  core_pkg::net_addr_t net_addr_i,
    input  core_pkg::data_t     net_data_i,
    output logic                imem_wr_o,
    output logic                reg_wr_o,
    output logic                pc_wr_o,
    output core_pkg::net_addr_t cmd_addr_o,
    output core_pkg::data_t     cmd_data_o
);

    import core_pkg::*;

    logic      valid_r;
    logic      external_r;
    logic      bc_r;
    ring_id_t  ring_id_r;
    net_op_e   op_r;
    net_addr_t addr_r;
    data_t     data_r;
    logic      id_match;
    logic      exec_pkt;

    // Packet qualifier
    always_ff @(posedge clk)
    begin
        if (reset)
            valid_r <= 1'b0;
        else
            valid_r <= net_valid_i;
    end

    // Header and payload, one cycle behind the ring
    always_ff @(posedge clk)
    begin
        external_r <= net_external_i;
        bc_r       <= net_bc_i;
        ring_id_r  <= net_ring_id_i;
        op_r       <= net_op_i;
        addr_r     <= net_addr_i;
        data_r     <= net_data_i;
    end

    assign id_match = (ring_id_r == ring_id_p);

    // Own ID and not broadcast, or foreign ID and broadcast
    // A broadcast with our own ID came from this tile and is dropped
    assign exec_pkt = valid_r & ~external_r & (id_match ^ bc_r);

    // One pulse per executed packet
    assign pc_wr_o   = exec_pkt & (op_r == NET_PC);
    assign imem_wr_o = exec_pkt & (op_r == NET_INSTR);
    assign reg_wr_o  = exec_pkt & (op_r == NET_REG);

    assign cmd_addr_o = addr_r;
    assign cmd_data_o = data_r;

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module fetch_unit
(
    input  logic                clk,
    input  logic                reset,
    input  logic                imem_wr_i,
    input  logic                pc_wr_i,
    input  core_pkg::net_addr_t cmd_addr_i,
    input  core_pkg::data_t     cmd_data_i,
    input  logic                reg_wr_i,
    output core_pkg::instr_t    instr_o,
    output core_pkg::pc_t       pc_plus4_o,
    output logic                stall_o,
    output logic                start_o,
    output logic                running_o
);

    import core_pkg::*;

    run_state_e                  state_r;
    pc_t                         pc_r;
    pc_t                         pc_n;
    logic                        pc_wen;
    logic                        pc_wen_r;
    logic [`IMEM_ADDR_WIDTH-1:0] imem_addr;
    instr_t                      imem [2**`IMEM_ADDR_WIDTH];
    instr_t                      imem_out;
    instr_t                      instr_r;

    // PC write only counts while idle
    assign start_o   = pc_wr_i & (state_r == IDLE);
    assign running_o = (state_r == RUN);

    // Whole pipeline freezes while idle or during a network write
    assign stall_o = (state_r == IDLE) | imem_wr_i | reg_wr_i;

    assign pc_plus4_o = pc_r + pc_t'(4);
    assign pc_wen     = start_o | ~stall_o;

    // Start address arrives as a word index
    always_comb
    begin
        if (start_o)
            pc_n = pc_t'({cmd_addr_i[`IMEM_ADDR_WIDTH-1:0], 2'b00});
        else
            pc_n = pc_plus4_o;
    end

    // Network write owns the single port for its cycle
    assign imem_addr = imem_wr_i ? cmd_addr_i[`IMEM_ADDR_WIDTH-1:0]
                                 : pc_n[2 +: `IMEM_ADDR_WIDTH];

    // Synchronous single-port instruction memory, read with next PC
    // Output moves on every cycle without a write
    always_ff @(posedge clk)
    begin
        if (imem_wr_i)
            imem[imem_addr] <= cmd_data_i;
        else
            imem_out <= imem[imem_addr];
    end

    // Memory output is stale after a stall, so replay the held word
    assign instr_o = pc_wen_r ? imem_out : instr_r;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_r  <= IDLE;
            pc_r     <= '0;
            pc_wen_r <= 1'b0;
            instr_r  <= '0;
        end
        else
        begin
            // No halt, so RUN holds until reset
            if (start_o)
                state_r <= RUN;
            if (pc_wen)
                pc_r <= pc_n;
            pc_wen_r <= pc_wen;
            instr_r  <= instr_o;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module reg_file
(
    input  logic                       clk,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr_i,
    input  logic                       wr_en_i,
    input  logic [`REG_ADDR_WIDTH-1:0] wr_addr_i,
    input  logic [`DATA_WIDTH-1:0]     wr_data_i,
    output logic [`DATA_WIDTH-1:0]     rs1_data_o,
    output logic [`DATA_WIDTH-1:0]     rs2_data_o
);

    logic [`DATA_WIDTH-1:0] regs [2**`REG_ADDR_WIDTH];

    // One write port, shared by network and write-back
    // x0 may be written, the read side hides it
    always_ff @(posedge clk)
    begin
        if (wr_en_i)
            regs[wr_addr_i] <= wr_data_i;
    end

    // Combinational reads with x0 tied to zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== logic/exec_alu.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module exec_alu
(
    input  core_pkg::instr_t instr_i,
    input  core_pkg::data_t  rs1_i,
    input  core_pkg::data_t  rs2_i,
    output core_pkg::data_t  result_o,
    output logic             writes_rf_o
);

    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_op;
    logic       is_op_imm;
    logic       is_sub;
    logic       funct_ok;
    data_t      imm;
    data_t      op_b;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign is_op     = (opcode == `OPCODE_OP);
    assign is_op_imm = (opcode == `OPCODE_OP_IMM);

    // funct7 bit 5 picks SUB, register form only
    assign is_sub = is_op & instr_i[30];

    // I-type immediate, sign extended
    assign imm  = {{(`DATA_WIDTH-12){instr_i[31]}}, instr_i[31:20]};
    assign op_b = is_op ? rs2_i : imm;

    always_comb
    begin
        funct_ok = 1'b1;
        case (funct3)
            `FUNCT3_ADD: result_o = is_sub ? (rs1_i - op_b) : (rs1_i + op_b);
            `FUNCT3_SLL: result_o = rs1_i << op_b[4:0];
            `FUNCT3_SLT: result_o = data_t'($signed(rs1_i) < $signed(op_b));
            `FUNCT3_XOR: result_o = rs1_i ^ op_b;
            `FUNCT3_SRL: result_o = rs1_i >> op_b[4:0];
            `FUNCT3_OR:  result_o = rs1_i | op_b;
            `FUNCT3_AND: result_o = rs1_i & op_b;
            default:
            begin
                // SLTU is not supported
                result_o = '0;
                funct_ok = 1'b0;
            end
        endcase
    end

    // Anything else travels as a bubble
    assign writes_rf_o = (is_op | is_op_imm) & funct_ok;

endmodule

// ==== logic/vanilla_core.sv ====
`timescale 1ns/1ns

module vanilla_core
#(
    parameter core_pkg::ring_id_t ring_id_p = '0
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 net_valid_i,
    input  logic                 net_external_i,
    input  logic                 net_bc_i,
    input  core_pkg::ring_id_t   net_ring_id_i,
    input  core_pkg::net_op_e    net_op_i,
    input  core_pkg::net_addr_t  net_addr_i,
    input  core_pkg::data_t      net_data_i,
    output logic                 retire_valid_o,
    output core_pkg::reg_addr_t  retire_rd_o,
    output core_pkg::data_t      retire_data_o,
    output logic                 running_o
);

    import core_pkg::*;

    logic      net_imem_wr;
    logic      net_reg_wr;
    logic      net_pc_wr;
    net_addr_t cmd_addr;
    data_t     cmd_data;
    instr_t    if_instr;
    logic      stall;
    logic      start;
    instr_t    id_instr_r;
    data_t     rf_rs1;
    data_t     rf_rs2;
    data_t     rs1_to_exe;
    data_t     rs2_to_exe;
    instr_t    exe_instr_r;
    data_t     exe_rs1_r;
    data_t     exe_rs2_r;
    data_t     alu_rs1;
    data_t     alu_rs2;
    data_t     alu_result;
    logic      alu_writes_rf;
    logic      mem_writes_r;
    reg_addr_t mem_rd_r;
    data_t     mem_data_r;
    logic      wb_writes_r;
    reg_addr_t wb_rd_r;
    data_t     wb_data_r;
    logic      rf_wen;

    // Source matches a pending write, x0 never matches
    function automatic logic src_hit(input reg_addr_t rs, input logic wr, input reg_addr_t rd);
        src_hit = wr & (rs != '0) & (rs == rd);
    endfunction

    net_cmd_decode #(.ring_id_p(ring_id_p)) i_net_cmd_decode
    (
        .clk            (clk),
        .reset          (reset),
        .net_valid_i    (net_valid_i),
        .net_external_i (net_external_i),
        .net_bc_i       (net_bc_i),
        .net_ring_id_i  (net_ring_id_i),
        .net_op_i       (net_op_i),
        .net_addr_i     (net_addr_i),
        .net_data_i     (net_data_i),
        .imem_wr_o      (net_imem_wr),
        .reg_wr_o       (net_reg_wr),
        .pc_wr_o        (net_pc_wr),
        .cmd_addr_o     (cmd_addr),
        .cmd_data_o     (cmd_data)
    );

    // Link address has no consumer without jumps
    fetch_unit i_fetch_unit
    (
        .clk        (clk),
        .reset      (reset),
        .imem_wr_i  (net_imem_wr),
        .pc_wr_i    (net_pc_wr),
        .cmd_addr_i (cmd_addr),
        .cmd_data_i (cmd_data),
        .reg_wr_i   (net_reg_wr),
        .instr_o    (if_instr),
        .pc_plus4_o (),
        .stall_o    (stall),
        .start_o    (start),
        .running_o  (running_o)
    );

    // IF to ID, a cleared word decodes as a bubble
    always_ff @(posedge clk)
    begin
        if (reset | start)
            id_instr_r <= '0;
        else if (~stall)
            id_instr_r <= if_instr;
    end

    // Network command wins the write port, and it stalls WB anyway
    assign rf_wen = net_reg_wr | (wb_writes_r & ~stall);

    reg_file i_reg_file
    (
        .clk        (clk),
        .rs1_addr_i (id_instr_r[19:15]),
        .rs2_addr_i (id_instr_r[24:20]),
        .wr_en_i    (rf_wen),
        .wr_addr_i  (net_reg_wr ? reg_addr_t'(cmd_addr) : wb_rd_r),
        .wr_data_i  (net_reg_wr ? cmd_data : wb_data_r),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2)
    );

    // WB bypass into ID covers the write landing this same edge
    assign rs1_to_exe = src_hit(id_instr_r[19:15], wb_writes_r, wb_rd_r) ? wb_data_r : rf_rs1;
    assign rs2_to_exe = src_hit(id_instr_r[24:20], wb_writes_r, wb_rd_r) ? wb_data_r : rf_rs2;

    // ID to EXE
    always_ff @(posedge clk)
    begin
        if (reset | start)
            exe_instr_r <= '0;
        else if (~stall)
        begin
            exe_instr_r <= id_instr_r;
            exe_rs1_r   <= rs1_to_exe;
            exe_rs2_r   <= rs2_to_exe;
        end
    end

    // EXE forwarding, MEM is younger so it goes first
    always_comb
    begin
        if (src_hit(exe_instr_r[19:15], mem_writes_r, mem_rd_r))
            alu_rs1 = mem_data_r;
        else if (src_hit(exe_instr_r[19:15], wb_writes_r, wb_rd_r))
            alu_rs1 = wb_data_r;
        else
            alu_rs1 = exe_rs1_r;
        if (src_hit(exe_instr_r[24:20], mem_writes_r, mem_rd_r))
            alu_rs2 = mem_data_r;
        else if (src_hit(exe_instr_r[24:20], wb_writes_r, wb_rd_r))
            alu_rs2 = wb_data_r;
        else
            alu_rs2 = exe_rs2_r;
    end

    exec_alu i_exec_alu
    (
        .instr_i     (exe_instr_r),
        .rs1_i       (alu_rs1),
        .rs2_i       (alu_rs2),
        .result_o    (alu_result),
        .writes_rf_o (alu_writes_rf)
    );

    // EXE to MEM and MEM to WB, no memory access in between
    always_ff @(posedge clk)
    begin
        if (reset | start)
        begin
            mem_writes_r <= 1'b0;
            wb_writes_r  <= 1'b0;
        end
        else if (~stall)
        begin
            mem_writes_r <= alu_writes_rf;
            mem_rd_r     <= exe_instr_r[11:7];
            mem_data_r   <= alu_result;
            wb_writes_r  <= mem_writes_r;
            wb_rd_r      <= mem_rd_r;
            wb_data_r    <= mem_data_r;
        end
    end

    // Shows the WB write that commits on the coming edge
    assign retire_valid_o = wb_writes_r & ~stall;
    assign retire_rd_o    = wb_rd_r;
    assign retire_data_o  = wb_data_r;

endmodule

// ==== tb/core_checker.sv ====
`timescale 1ns/1ns

module core_checker
(
    input  logic                clk,
    input  logic                reset,
    input  logic                retire_valid_i,
    input  core_pkg::reg_addr_t retire_rd_i,
    input  core_pkg::data_t     retire_data_i,
    input  logic                running_i,
    input  logic                run_chk_i,
    input  logic                exp_run_i,
    output logic                done_o,
    output int                  mismatch_count_o,
    output int                  extra_count_o,
    output int                  missing_count_o
);

    import core_pkg::*;

    localparam int NUM_EXP = 22;

    reg_addr_t exp_rd   [NUM_EXP];
    data_t     exp_data [NUM_EXP];
    int        idx;

    task automatic set_expected(input int i, input reg_addr_t rd, input data_t data);
        exp_rd[i]   = rd;
        exp_data[i] = data;
    endtask

    // Retires in program order, worked out by hand from the ALU rules
    initial
    begin
        idx              = 0;
        mismatch_count_o = 0;
        extra_count_o    = 0;
        set_expected(0,  5'd7,  32'h0000_0005);
        set_expected(1,  5'd8,  32'h0000_0002);
        set_expected(2,  5'd9,  32'h0000_0014);
        set_expected(3,  5'd10, 32'h0400_0007);
        set_expected(4,  5'd11, 32'h0000_0001);
        set_expected(5,  5'd12, 32'h0400_0013);
        set_expected(6,  5'd13, 32'h0400_0013);
        set_expected(7,  5'd14, 32'h0000_0010);
        set_expected(8,  5'd15, 32'h0000_000F);
        set_expected(9,  5'd16, 32'h0000_0001);
        set_expected(10, 5'd17, 32'h8000_0000);
        set_expected(11, 5'd18, 32'h0800_0000);
        set_expected(12, 5'd19, 32'hF7FF_FFFF);
        set_expected(13, 5'd20, 32'h0800_00F0);
        set_expected(14, 5'd21, 32'h0000_00F0);
        // x0 write still retires
        set_expected(15, 5'd0,  32'h0000_001C);
        set_expected(16, 5'd22, 32'h0000_0055);
        set_expected(17, 5'd23, 32'h0000_0700);
        set_expected(18, 5'd24, 32'h0000_0003);
        set_expected(19, 5'd25, 32'h0000_0003);
        set_expected(20, 5'd26, 32'h0000_1249);
        set_expected(21, 5'd27, 32'h0000_1349);
    end

    assign done_o          = (idx >= NUM_EXP);
    assign missing_count_o = NUM_EXP - idx;

    // Sampled on the rising edge, the values that commit on that edge
    always @(posedge clk)
    begin
        if (!reset)
        begin
            // Running flag expected when a packet goes out
            if (run_chk_i && (running_i !== exp_run_i))
            begin
                mismatch_count_o++;
                $display("FAILED running_o: expected %h, got %h at %0t",
                         exp_run_i, running_i, $time);
            end
            if ((retire_valid_i !== 1'b0) && (retire_valid_i !== 1'b1))
            begin
                mismatch_count_o++;
                $display("retire_valid_o is unknown at %0t", $time);
            end
            else if (retire_valid_i)
            begin
                if (running_i !== 1'b1)
                begin
                    mismatch_count_o++;
                    $display("A retire appeared while the core was idle at %0t", $time);
                end
                if (idx >= NUM_EXP)
                begin
                    extra_count_o++;
                    $display("Unexpected extra retire to x%0d at %0t", retire_rd_i, $time);
                end
                else
                begin
                    if (retire_rd_i !== exp_rd[idx])
                    begin
                        mismatch_count_o++;
                        $display("FAILED retire_rd_o (retire %0d): expected %h, got %h",
                                 idx, exp_rd[idx], retire_rd_i);
                    end
                    if (retire_data_i !== exp_data[idx])
                    begin
                        mismatch_count_o++;
                        $display("FAILED retire_data_o (retire %0d): expected %h, got %h",
                                 idx, exp_data[idx], retire_data_i);
                    end
                    idx++;
                end
            end
        end
    end

endmodule

// ==== tb/tb_core.sv ====
`timescale 1ns/1ns
`include "core_defs.svh"

module tb_core;

    import core_pkg::*;

    localparam int       CLK_PERIOD = 4;
    localparam int       IMEM_WORDS = 2**`IMEM_ADDR_WIDTH;
    localparam ring_id_t OWN_ID     = 4'd3;

    // Ring packet with its trailing idle cycles and the running_o value expected when it goes out
    typedef struct packed {
        ring_id_t  ring_id;
        logic      bc;
        logic      ext;
        net_op_e   op;
        net_addr_t addr;
        data_t     data;
        int        delay;
        logic      exp_run;
    } pkt_row_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      net_valid;
    logic      net_external;
    logic      net_bc;
    ring_id_t  net_ring_id;
    net_op_e   net_op;
    net_addr_t net_addr;
    data_t     net_data;
    logic      retire_valid;
    reg_addr_t retire_rd;
    data_t     retire_data;
    logic      running;
    logic      run_chk;
    logic      exp_run;
    logic      retire_done;
    int        mismatch_count;
    int        extra_count;
    int        missing_count;
    pkt_row_t  rows [$];
    logic      table_ready = 1'b0;

    always #(CLK_PERIOD/2) clk = ~clk;

    vanilla_core #(.ring_id_p(OWN_ID)) i_dut
    (
        .clk            (clk),
        .reset          (reset),
        .net_valid_i    (net_valid),
        .net_external_i (net_external),
        .net_bc_i       (net_bc),
        .net_ring_id_i  (net_ring_id),
        .net_op_i       (net_op),
        .net_addr_i     (net_addr),
        .net_data_i     (net_data),
        .retire_valid_o (retire_valid),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data),
        .running_o      (running)
    );

    core_checker i_checker
    (
        .clk              (clk),
        .reset            (reset),
        .retire_valid_i   (retire_valid),
        .retire_rd_i      (retire_rd),
        .retire_data_i    (retire_data),
        .running_i        (running),
        .run_chk_i        (run_chk),
        .exp_run_i        (exp_run),
        .done_o           (retire_done),
        .mismatch_count_o (mismatch_count),
        .extra_count_o    (extra_count),
        .missing_count_o  (missing_count)
    );

    // Standard RV32 register and immediate encodings
    function automatic instr_t r_type(input logic [6:0] funct7, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] funct3,
                                      input reg_addr_t rd);
        r_type = {funct7, rs2, rs1, funct3, rd, `OPCODE_OP};
    endfunction

    function automatic instr_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                      input logic [2:0] funct3, input reg_addr_t rd);
        i_type = {imm, rs1, funct3, rd, `OPCODE_OP_IMM};
    endfunction

    task automatic add_row(input ring_id_t ring_id, input logic bc, input logic ext,
                           input net_op_e op, input int addr, input data_t data,
                           input int delay, input logic run);
        pkt_row_t row;
        row.ring_id = ring_id;
        row.bc      = bc;
        row.ext     = ext;
        row.op      = op;
        row.addr    = net_addr_t'(addr);
        row.data    = data;
        row.delay   = delay;
        row.exp_run = run;
        rows.push_back(row);
    endtask

    // Own-ID packets sent back to back while idle
    task automatic load_instr(input int addr, input instr_t word);
        add_row(OWN_ID, 1'b0, 1'b0, NET_INSTR, addr, word, 0, 1'b0);
    endtask

    task automatic load_reg(input int idx, input data_t value);
        add_row(OWN_ID, 1'b0, 1'b0, NET_REG, idx, value, 0, 1'b0);
    endtask

    task automatic build_table();
        int a;
        // Opcode zero decodes as a bubble with the word address in bits 12:7
        for (a = 0; a < IMEM_WORDS; a++)
            load_instr(a, data_t'(a) << 7);
        // Dependent chain covers MEM and WB forwards and the ID bypass
        load_instr(0,  r_type(7'h00, 5'd2,  5'd1,  `FUNCT3_ADD, 5'd7));
        load_instr(1,  r_type(7'h20, 5'd3,  5'd7,  `FUNCT3_ADD, 5'd8));
        load_instr(2,  r_type(7'h00, 5'd8,  5'd7,  `FUNCT3_SLL, 5'd9));
        load_instr(3,  r_type(7'h00, 5'd7,  5'd4,  `FUNCT3_SRL, 5'd10));
        load_instr(4,  r_type(7'h00, 5'd1,  5'd2,  `FUNCT3_SLT, 5'd11));
        load_instr(5,  r_type(7'h00, 5'd10, 5'd9,  `FUNCT3_XOR, 5'd12));
        load_instr(6,  r_type(7'h00, 5'd12, 5'd11, `FUNCT3_OR,  5'd13));
        load_instr(7,  r_type(7'h00, 5'd4,  5'd13, `FUNCT3_AND, 5'd14));
        // Immediate forms
        load_instr(8,  i_type(12'hFFF, 5'd14, `FUNCT3_ADD, 5'd15));
        load_instr(9,  i_type(12'd16,  5'd15, `FUNCT3_SLT, 5'd16));
        load_instr(10, i_type(12'd31,  5'd16, `FUNCT3_SLL, 5'd17));
        load_instr(11, i_type(12'd4,   5'd17, `FUNCT3_SRL, 5'd18));
        load_instr(12, i_type(12'hFFF, 5'd18, `FUNCT3_XOR, 5'd19));
        load_instr(13, i_type(12'h0F0, 5'd18, `FUNCT3_OR,  5'd20));
        load_instr(14, i_type(12'h0F0, 5'd19, `FUNCT3_AND, 5'd21));
        // Write x0 and read it back at distances 1 to 4
        load_instr(15, i_type(12'd7,   5'd1,  `FUNCT3_ADD, 5'd0));
        load_instr(16, r_type(7'h00, 5'd5,  5'd0,  `FUNCT3_ADD, 5'd22));
        load_instr(17, r_type(7'h20, 5'd0,  5'd6,  `FUNCT3_ADD, 5'd23));
        load_instr(18, r_type(7'h00, 5'd3,  5'd0,  `FUNCT3_OR,  5'd24));
        load_instr(19, r_type(7'h20, 5'd0,  5'd3,  `FUNCT3_ADD, 5'd25));
        // x30 arrives by packet while running
        load_instr(20, r_type(7'h00, 5'd1,  5'd30, `FUNCT3_ADD, 5'd26));
        load_instr(21, i_type(12'h100, 5'd26, `FUNCT3_ADD, 5'd27));
        load_reg(1, 32'h0000_0015);
        load_reg(2, 32'hFFFF_FFF0);
        load_reg(3, 32'h0000_0003);
        load_reg(4, 32'h8000_00F0);
        load_reg(5, 32'h0000_0055);
        // Dropped foreign imem write, foreign ID, external and own broadcast packets
        add_row(4'd6, 1'b0, 1'b0, NET_INSTR, 3, i_type(12'h7FF, 5'd0, `FUNCT3_ADD, 5'd10),
                0, 1'b0);
        add_row(4'd5, 1'b0, 1'b0, NET_REG, 5, 32'hDEAD_0001, 0, 1'b0);
        add_row(OWN_ID, 1'b0, 1'b1, NET_REG, 5, 32'hDEAD_0002, 0, 1'b0);
        add_row(OWN_ID, 1'b1, 1'b0, NET_REG, 5, 32'hDEAD_0003, 0, 1'b0);
        // Broadcast from another tile lands
        add_row(4'd9, 1'b1, 1'b0, NET_REG, 6, 32'h0000_0700, 0, 1'b0);
        // Foreign start is dropped and the start row checks that the core is still idle
        add_row(4'd5, 1'b0, 1'b0, NET_PC, 0, '0, 2, 1'b0);
        // Pipeline fills up so that the next register write stalls a busy WB
        add_row(OWN_ID, 1'b0, 1'b0, NET_PC, 0, '0, 6, 1'b0);
        // While running a register write stalls and a PC write is ignored
        add_row(OWN_ID, 1'b0, 1'b0, NET_REG, 30, 32'h0000_1234, 2, 1'b1);
        add_row(OWN_ID, 1'b0, 1'b0, NET_PC, 10, '0, 0, 1'b1);
    endtask

    // Called on a falling edge and returns on the falling edge for the next row
    task automatic apply_row(input pkt_row_t row);
        net_valid    = 1'b1;
        net_ring_id  = row.ring_id;
        net_bc       = row.bc;
        net_external = row.ext;
        net_op       = row.op;
        net_addr     = row.addr;
        net_data     = row.data;
        run_chk      = 1'b1;
        exp_run      = row.exp_run;
        @(negedge clk);
        net_valid = 1'b0;
        run_chk   = 1'b0;
        repeat (row.delay) @(negedge clk);
    endtask

    task automatic print_counts();
        $display("Errors: %0d mismatches, %0d extra retires, %0d missing retires",
                 mismatch_count, extra_count, missing_count);
    endtask

    initial
    begin
        reset        = 1'b1;
        net_valid    = 1'b0;
        net_external = 1'b0;
        net_bc       = 1'b0;
        net_ring_id  = '0;
        net_op       = NET_PC;
        net_addr     = '0;
        net_data     = '0;
        run_chk      = 1'b0;
        exp_run      = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (rows[i])
            apply_row(rows[i]);
        wait (retire_done);
        // Short window to catch extra retires
        repeat (8) @(negedge clk);
        print_counts();
        if ((mismatch_count == 0) && (extra_count == 0) && (missing_count == 0))
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // Watchdog scaled by the table length
    initial
    begin
        wait (table_ready);
        #(rows.size() * 20 * CLK_PERIOD);
        $display("Timeout: the expected retires did not all appear in time");
        print_counts();
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+logic
logic/core_pkg.sv
logic/net_cmd_decode.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/exec_alu.sv
logic/vanilla_core.sv
tb/core_checker.sv
tb/tb_core.sv

// ==== Bender.yml ====
package:
  name: vanilla_core

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/core_pkg.sv
      - logic/net_cmd_decode.sv
      - logic/fetch_unit.sv
      - logic/reg_file.sv
      - logic/exec_alu.sv
      - logic/vanilla_core.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/core_checker.sv
      - tb/tb_core.sv
